//--- clock_revo_pkg.sv
package clock_revo_pkg;

	// serializer word, one bit per clock50 cycle
	localparam int word_bits = 8;

	// one machine turn, counted in buckets
	localparam int revolution_buckets = 5120;

	// words per turn, one word covers word_bits buckets
	localparam int revolution_words = revolution_buckets / word_bits;

	// wide enough for revolution_words - 1
	localparam int revo_index_bits = 10;

	// alternating pattern, sent as the bunch clock
	localparam logic [word_bits-1:0] clock_word = 8'b10101010;

	// first word of a turn carries the marker in its msb
	// every other word of the turn is all zero
	localparam logic [word_bits-1:0] revo_marker = 8'b10000000;

	// reset release points, in clock50 cycles after the external reset
	localparam int serdes_reset_cycles = 512;
	localparam int revo_reset_cycles = 2048;

	// reset sequencer counter width
	// has to hold revo_reset_cycles without wrapping
	localparam int sequencer_bits = 12;

endpackage

//--- reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
	input logic clock50,
	input logic reset,
	output logic serdes_reset,
	output logic revo_reset
);
	import clock_revo_pkg::*;

	// last counter value before each release edge
	localparam logic [sequencer_bits-1:0] serdes_last =
		sequencer_bits'(serdes_reset_cycles - 1);
	localparam logic [sequencer_bits-1:0] revo_last =
		sequencer_bits'(revo_reset_cycles - 1);
	// counter stops here once the last reset is gone
	localparam logic [sequencer_bits-1:0] count_limit =
		sequencer_bits'(revo_reset_cycles);

	// number of cycles completed since reset went low
	logic [sequencer_bits-1:0] counter;

	always_ff @(posedge clock50) begin
		if (reset) begin
			counter <= '0;
		end else if (counter != count_limit) begin
			// saturates, so the releases happen once per reset
			counter <= counter + 1'b1;
		end
	end

	// both resets stay high until their cycle count is reached
	always_ff @(posedge clock50) begin
		if (reset) begin
			serdes_reset <= 1'b1;
			revo_reset <= 1'b1;
		end else begin
			// serializers come out first
			if (counter == serdes_last) begin
				serdes_reset <= 1'b0;
			end
			// revolution logic waits until the serializers have settled
			if (counter == revo_last) begin
				revo_reset <= 1'b0;
			end
		end
	end

endmodule

//--- word_serializer.sv
`timescale 1ns/1ps

module word_serializer (
	input logic clock50,
	input logic reset,
	input logic [clock_revo_pkg::word_bits-1:0] word,
	output logic serial,
	output logic word_strobe,
	output logic locked
);
	import clock_revo_pkg::*;

	localparam int count_bits = $clog2(word_bits);
	// strobe is registered, so it is set one slot early
	localparam logic [count_bits-1:0] pre_last_slot = count_bits'(word_bits - 2);

	// bit slot within the current word
	logic [count_bits-1:0] bit_count;
	// bits of the current word that are still to be sent
	logic [word_bits-1:0] shift_reg;

	// free running slot counter, wraps every word
	always_ff @(posedge clock50) begin
		if (reset) begin
			bit_count <= '0;
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// high during the last bit slot of every word
	// first one lands in the 8th cycle after release
	always_ff @(posedge clock50) begin
		if (reset) begin
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= (bit_count == pre_last_slot);
		end
	end

	// msb first
	// the msb goes straight to the output on the load edge,
	// the rest waits in the shift register
	always_ff @(posedge clock50) begin
		if (reset) begin
			shift_reg <= '0;
			serial <= 1'b0;
		end else if (word_strobe) begin
			shift_reg <= {word[word_bits-2:0], 1'b0};
			serial <= word[word_bits-1];
		end else begin
			shift_reg <= {shift_reg[word_bits-2:0], 1'b0};
			serial <= shift_reg[word_bits-1];
		end
	end

	// stands in for the serializer pll lock
	// sticky from the first word loaded
	always_ff @(posedge clock50) begin
		if (reset) begin
			locked <= 1'b0;
		end else if (word_strobe) begin
			locked <= 1'b1;
		end
	end

endmodule

//--- revolution_generator.sv
`timescale 1ns/1ps

module revolution_generator (
	input logic clock50,
	input logic reset,
	input logic word_strobe,
	output logic [clock_revo_pkg::word_bits-1:0] revo_word,
	output logic revo,
	output logic revo_toggle
);
	import clock_revo_pkg::*;

	// last word of a turn, the index wraps after it
	localparam logic [revo_index_bits-1:0] last_index =
		revo_index_bits'(revolution_words - 1);

	// word position within the turn
	logic [revo_index_bits-1:0] index;
	logic [revo_index_bits-1:0] index_next;

	// index that takes effect on the next word strobe
	always_comb begin
		if (index == last_index) begin
			index_next = '0;
		end else begin
			index_next = index + 1'b1;
		end
	end

	// one step per word, only on the serializer strobe
	always_ff @(posedge clock50) begin
		if (reset) begin
			index <= '0;
		end else if (word_strobe) begin
			index <= index_next;
		end
	end

	// word for the revo serializer
	// the marker is set when the index wraps and held for exactly one word,
	// the serializer picks it up on the following strobe
	always_ff @(posedge clock50) begin
		if (reset) begin
			revo_word <= '0;
		end else if (word_strobe) begin
			if (index_next == '0) begin
				revo_word <= revo_marker;
			end else begin
				revo_word <= '0;
			end
		end
	end

	// pulse in the strobe cycle that hands the marker to the serializer,
	// so the marker bit shows up on the serial line one cycle later
	// revo_word is zero in reset, which keeps this low there as well
	assign revo = word_strobe && (revo_word == revo_marker);

	// slow level for the led, one flip per turn
	always_ff @(posedge clock50) begin
		if (reset) begin
			revo_toggle <= 1'b0;
		end else if (revo) begin
			revo_toggle <= ~revo_toggle;
		end
	end

endmodule

//--- clock_revo_generator.sv
`timescale 1ns/1ps

module clock_revo_generator (
	input logic clock50,
	input logic reset,
	output logic clock_bit,
	output logic revo_bit,
	output logic revo,
	output logic [7:0] led
);
	import clock_revo_pkg::*;

	// staged internal resets
	logic serdes_reset;
	logic revo_reset;

	// serializer status
	logic clock_strobe;
	logic clock_locked;
	logic revo_locked;

	// revolution generator outputs
	logic [word_bits-1:0] revo_word;
	logic revo_toggle;

	// serializers first, revolution logic later
	reset_sequencer reset_sequencer_inst (
		.clock50(clock50),
		.reset(reset),
		.serdes_reset(serdes_reset),
		.revo_reset(revo_reset)
	);

	// bunch clock, constant pattern
	// its word strobe also paces the revolution counter
	word_serializer clock_serializer (
		.clock50(clock50),
		.reset(serdes_reset),
		.word(clock_word),
		.serial(clock_bit),
		.word_strobe(clock_strobe),
		.locked(clock_locked)
	);

	// revolution marker stream
	// same reset as the clock serializer, so both strobes line up
	word_serializer revo_serializer (
		.clock50(clock50),
		.reset(serdes_reset),
		.word(revo_word),
		.serial(revo_bit),
		.word_strobe(),
		.locked(revo_locked)
	);

	revolution_generator revolution_generator_inst (
		.clock50(clock50),
		.reset(revo_reset),
		.word_strobe(clock_strobe),
		.revo_word(revo_word),
		.revo(revo),
		.revo_toggle(revo_toggle)
	);

	// status leds, msb first
	// 7 clock lock, 6 revo lock, 4 turn toggle, 2 and 1 internal resets
	assign led = {
		clock_locked,
		revo_locked,
		1'b0,
		revo_toggle,
		1'b0,
		serdes_reset,
		revo_reset,
		1'b0
	};

endmodule

//--- clock_revo_generator_properties.sv
`timescale 1ns/1ps

module clock_revo_generator_properties (
	input logic clock50,
	input logic serdes_reset,
	input logic clock_strobe,
	input logic revo,
	input logic [7:0] led
);

	// one strobe per word, none in between
	strobe_spacing: assert property (@(posedge clock50) disable iff (serdes_reset)
		clock_strobe |=> !clock_strobe [*7] ##1 clock_strobe)
		else $error("word strobe not spaced by 8 cycles");

	revo_single_cycle: assert property (@(posedge clock50)
		revo |=> !revo)
		else $error("revo high for two cycles in a row");

	// clock lock only drops while the serializers are held in reset
	lock_held: assert property (@(posedge clock50) disable iff (serdes_reset)
		!$fell(led[7]))
		else $error("clock lock led fell outside reset");

endmodule

//--- clock_revo_generator_tb.sv
`timescale 1ns/1ps

module clock_revo_generator_tb;

	// expected timing, in clock50 cycles after reset deasserts
	localparam int serdes_release = 512;
	localparam int revo_release = 2048;
	localparam int word_length = 8;
	localparam int turn_length = 5120;
	localparam int clock_check_cycles = 64;
	// one sequencer wait plus three turns, with margin
	localparam int timeout_cycles = 20000;

	logic clock50;
	logic reset;
	logic clock_bit;
	logic revo_bit;
	logic revo;
	logic [7:0] led;

	int error_count;
	int check_count;
	// cycles since reset last went low, restarted by apply_reset
	int cycle_count;
	int lock_cycle;
	logic first_clock_bit;

	clock_revo_generator clock_revo_generator_inst (
		.clock50(clock50),
		.reset(reset),
		.clock_bit(clock_bit),
		.revo_bit(revo_bit),
		.revo(revo),
		.led(led)
	);

	bind clock_revo_generator clock_revo_generator_properties properties_inst (
		.clock50(clock50),
		.serdes_reset(serdes_reset),
		.clock_strobe(clock_strobe),
		.revo(revo),
		.led(led)
	);

	always #50 clock50 = ~clock50;

	always @(posedge clock50) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			$display("timeout: no result within %0d cycles after reset", timeout_cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("mismatch at %0t ns: %s, got %0d, expected %0d",
				$time, what, actual, expected);
		end
	endtask

	// one clock50 cycle, ends at the falling edge where outputs are stable
	task automatic next_cycle();
		@(posedge clock50);
		@(negedge clock50);
	endtask

	// holds reset for 8 cycles and checks every output at its reset value
	task automatic apply_reset();
		reset = 1'b1;
		repeat (8) next_cycle();
		check_value("clock_bit in reset", clock_bit, 1'b0);
		check_value("revo_bit in reset", revo_bit, 1'b0);
		check_value("revo in reset", revo, 1'b0);
		check_value("led in reset", led, 8'b0000_0110);
		reset = 1'b0;
		cycle_count = 0;
	endtask

	task automatic wait_for_revo();
		while (revo !== 1'b1) begin
			next_cycle();
		end
	endtask

	task automatic check_reset_staging();
		int serdes_fall;
		int revo_fall;
		int revo_lock;
		serdes_fall = -1;
		revo_fall = -1;
		revo_lock = -1;
		lock_cycle = -1;
		while (revo_fall < 0) begin
			next_cycle();
			if (serdes_fall < 0 && led[2] === 1'b0) serdes_fall = cycle_count;
			if (revo_fall < 0 && led[1] === 1'b0) revo_fall = cycle_count;
			if (revo_lock < 0 && led[6] === 1'b1) revo_lock = cycle_count;
			if (lock_cycle < 0 && led[7] === 1'b1) begin
				lock_cycle = cycle_count;
				first_clock_bit = clock_bit;
			end
		end
		check_value("serdes reset release cycle", serdes_fall, serdes_release);
		check_value("revo reset release cycle", revo_fall, revo_release);
		// both locks follow the first capture, one word after release
		check_value("clock lock cycle", lock_cycle, serdes_release + word_length);
		check_value("revo lock cycle", revo_lock, serdes_release + word_length);
	endtask

	task automatic check_clock_pattern();
		logic expected_bit;
		check_value("first clock_bit after lock", first_clock_bit, 1'b1);
		for (int i = 0; i < clock_check_cycles; i++) begin
			next_cycle();
			expected_bit = ((cycle_count - lock_cycle) % 2 == 0);
			check_value("clock_bit pattern", clock_bit, expected_bit);
			check_value("clock lock held", led[7], 1'b1);
		end
	endtask

	// ends in the cycle after the second revo pulse
	// the toggle starts from its reset value, so its levels are known
	task automatic check_revolution_period();
		int first_pulse;
		wait_for_revo();
		first_pulse = cycle_count;
		check_value("revo toggle before first pulse", led[4], 1'b0);
		next_cycle();
		check_value("revo toggle after first pulse", led[4], 1'b1);
		wait_for_revo();
		check_value("revo period", cycle_count - first_pulse, turn_length);
		check_value("revo toggle before second pulse", led[4], 1'b1);
		next_cycle();
		check_value("revo toggle after second pulse", led[4], 1'b0);
	endtask

	// entered in the cycle after a revo pulse, runs one full turn
	task automatic check_marker_placement();
		logic prev_revo;
		int markers;
		prev_revo = 1'b1;
		markers = 0;
		for (int i = 0; i <= turn_length; i++) begin
			check_value("revo_bit follows revo", revo_bit, prev_revo);
			if (revo_bit === 1'b1) begin
				markers++;
				check_value("clock_bit under marker", clock_bit, 1'b1);
			end
			if (i < turn_length) begin
				prev_revo = revo;
				next_cycle();
			end
		end
		check_value("markers in one turn", markers, 2);
	endtask

	task automatic check_re_reset();
		int reset_wait;
		reset_wait = $urandom % 301;
		repeat (reset_wait) next_cycle();
		apply_reset();
		check_reset_staging();
		check_clock_pattern();
		check_revolution_period();
	endtask

	initial begin
		clock50 = 1'b0;
		reset = 1'b1;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		lock_cycle = -1;
		first_clock_bit = 1'b0;
		void'($urandom(32'h70aa));
		@(negedge clock50);
		apply_reset();
		check_reset_staging();
		check_clock_pattern();
		check_revolution_period();
		check_marker_placement();
		check_re_reset();
		$display("tests done, %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- tb.f
clock_revo_pkg.sv
reset_sequencer.sv
word_serializer.sv
revolution_generator.sv
clock_revo_generator.sv
clock_revo_generator_properties.sv
clock_revo_generator_tb.sv

//--- Bender.yml
package:
  name: clock_revo_generator

sources:
  - clock_revo_pkg.sv
  - reset_sequencer.sv
  - word_serializer.sv
  - revolution_generator.sv
  - clock_revo_generator.sv
  - target: test
    files:
      - clock_revo_generator_properties.sv
      - clock_revo_generator_tb.sv
